// ==== design/ddr3_dbg_pkg.sv ====
/*
 * DDR3 debug host shared definitions.
 * Word and address widths, store read latency, the host request,
 * store command and read return structs, and the word store states.
 */
package ddr3_dbg_pkg;

	// ******************************
	// Memory geometry.
	// ******************************
	localparam int WORD_BITS      = 128; // One memory word.
	localparam int WORD_BYTES     = 16;  // Byte lanes per word.
	localparam int BYTE_IDX_BITS  = 4;   // Byte index inside a word.
	localparam int HOST_ADDR_BITS = 12;  // Host byte address, 4 KB.
	localparam int WORD_ADDR_BITS = 8;   // 256 words deep.
	localparam int READ_LATENCY   = 3;   // Acceptance to read return, in clocks.

	// Host byte request, 22 bits.
	typedef struct packed {
		logic                      rd;    // Read strobe, one clock.
		logic                      wr;    // Write strobe, one clock.
		logic [HOST_ADDR_BITS-1:0] addr;  // Byte address.
		logic [7:0]                wdata; // Write byte.
	} host_req_t;

	// Word store command, 157 bits.
	typedef struct packed {
		logic                      write; // 1 = write, 0 = read.
		logic [WORD_ADDR_BITS-1:0] addr;  // Word address.
		logic [WORD_BITS-1:0]      wdata; // Byte copied across every lane.
		logic [WORD_BYTES-1:0]     wmask; // One-hot lane enable.
		logic [BYTE_IDX_BITS-1:0]  vect;  // Return vector, the byte index.
	} seq_cmd_t;

	// Read return, 132 bits.
	typedef struct packed {
		logic [WORD_BITS-1:0]     data; // Whole word read.
		logic [BYTE_IDX_BITS-1:0] vect; // Vector handed back with the data.
	} seq_rdata_t;

	// Word store states.
	typedef enum logic {
		CLEARING = 1'b0, // Post reset zero fill.
		READY    = 1'b1  // Taking commands.
	} store_state_t;

endpackage

// ==== design/ddr3_dbg_top.sv ====
/*
 * DDR3 debug host top level.
 * Host byte port into the command bridge, word store as the
 * sequencer stand-in, read return path and status LEDs.
 */
`timescale 1ns/1ps

module ddr3_dbg_top (
	input  logic                    DDR3_CLK_25,
	input  logic                    RESET,
	input  ddr3_dbg_pkg::host_req_t host_req,
	output logic                    host_busy,
	output logic                    host_rd_rdy,
	output logic [7:0]              host_rd_data,
	output logic                    store_ready,
	output logic [7:0]              led
);
	import ddr3_dbg_pkg::*;

	// ******************************
	// Store port wires.
	// ******************************
	seq_cmd_t    seq_cmd;
	logic        cmd_ena_t;
	logic        busy_t;
	seq_rdata_t  rdata;
	logic        rdata_rdy_t;
	logic [15:0] read_count;

	host_cmd_bridge u_bridge (
		.DDR3_CLK_25 (DDR3_CLK_25),
		.RESET       (RESET),
		.host_req    (host_req),
		.busy_t      (busy_t),
		.host_busy   (host_busy),
		.cmd_ena_t   (cmd_ena_t),
		.seq_cmd     (seq_cmd)
	);

	seq_word_store u_store (
		.DDR3_CLK_25 (DDR3_CLK_25),
		.RESET       (RESET),
		.cmd_ena_t   (cmd_ena_t),
		.seq_cmd     (seq_cmd),
		.busy_t      (busy_t),
		.rdata       (rdata),
		.rdata_rdy_t (rdata_rdy_t),
		.store_ready (store_ready)
	);

	read_return u_read_return (
		.DDR3_CLK_25  (DDR3_CLK_25),
		.RESET        (RESET),
		.rdata        (rdata),
		.rdata_rdy_t  (rdata_rdy_t),
		.host_rd_rdy  (host_rd_rdy),
		.host_rd_data (host_rd_data),
		.read_count   (read_count)
	);

	status_report u_status (
		.DDR3_CLK_25 (DDR3_CLK_25),
		.RESET       (RESET),
		.store_ready (store_ready),
		.read_count  (read_count),
		.led         (led)
	);

endmodule

// ==== design/host_cmd_bridge.sv ====
/*
 * Host command bridge.
 * Captures one byte read or write from the host, spreads the byte over
 * all 16 lanes with a one-hot lane mask, and passes the command to the
 * word store over the cmd_ena_t / busy_t toggle handshake.
 */
`timescale 1ns/1ps

module host_cmd_bridge (
	input  logic                    DDR3_CLK_25,
	input  logic                    RESET,
	input  ddr3_dbg_pkg::host_req_t host_req,
	input  logic                    busy_t,
	output logic                    host_busy,
	output logic                    cmd_ena_t,
	output ddr3_dbg_pkg::seq_cmd_t  seq_cmd
);
	import ddr3_dbg_pkg::*;

	logic                     req_t;      // Toggles once per captured request.
	logic                     req_any;    // Read or write strobe present.
	logic                     store_idle; // Store has taken every toggle so far.
	logic [BYTE_IDX_BITS-1:0] lane;       // Target lane, 15 - byte index.

	assign req_any    = host_req.rd || host_req.wr;
	assign store_idle = (busy_t == cmd_ena_t);
	assign lane       = ~host_req.addr[BYTE_IDX_BITS-1:0]; // Byte 0 sits in the top lane.

	// ******************************
	// Command build.
	// ******************************
	always_ff @(posedge DDR3_CLK_25) begin
		if (req_any && !host_busy) begin
			seq_cmd.write <= host_req.wr;                                   // Write wins over read.
			seq_cmd.addr  <= host_req.addr[HOST_ADDR_BITS-1:BYTE_IDX_BITS]; // Drop the byte index.
			seq_cmd.wdata <= {WORD_BYTES{host_req.wdata}};                  // Byte on every lane.
			seq_cmd.wmask <= WORD_BYTES'(1) << lane;                        // Only the target lane.
			seq_cmd.vect  <= host_req.addr[BYTE_IDX_BITS-1:0];              // Comes back with the read.
		end
	end

	// ******************************
	// Toggle handshake.
	// ******************************
	always_ff @(posedge DDR3_CLK_25) begin
		if (RESET) begin
			req_t     <= 1'b0;
			cmd_ena_t <= 1'b0;
			host_busy <= 1'b0;
		end else begin
			if (req_any && !host_busy) begin
				req_t     <= !req_t; // New command pending.
				host_busy <= 1'b1;
			end else if (host_busy && store_idle && (cmd_ena_t == req_t)) begin
				host_busy <= 1'b0;   // Store has taken it.
			end

			// Pass the pending toggle one clock later, only while the store is caught up.
			if (store_idle) cmd_ena_t <= req_t;
		end
	end

	// Host must hold off until host_busy falls, else the request is lost.
	a_no_req_when_busy: assert property (@(posedge DDR3_CLK_25) disable iff (RESET)
		host_busy |-> !req_any);

endmodule

// ==== design/read_return.sv ====
/*
 * Read return path.
 * Edge-detects the store's rdata_rdy_t toggle into a one clock
 * host_rd_rdy pulse, picks the requested byte out of the returned
 * word, and counts completed reads.
 */
`timescale 1ns/1ps

module read_return (
	input  logic                     DDR3_CLK_25,
	input  logic                     RESET,
	input  ddr3_dbg_pkg::seq_rdata_t rdata,
	input  logic                     rdata_rdy_t,
	output logic                     host_rd_rdy,
	output logic [7:0]               host_rd_data,
	output logic [15:0]              read_count
);
	import ddr3_dbg_pkg::*;

	logic                     rdy_dly;  // First toggle register.
	logic                     rdy_seen; // Second toggle register.
	seq_rdata_t               rdata_q;  // Word aligned with rdy_dly.
	logic [BYTE_IDX_BITS-1:0] lane;     // Lane of the returned byte.

	assign lane = ~rdata_q.vect; // 15 - byte index.

	// ******************************
	// Toggle detect and counter.
	// ******************************
	always_ff @(posedge DDR3_CLK_25) begin
		if (RESET) begin
			rdy_dly     <= 1'b0;
			rdy_seen    <= 1'b0;
			host_rd_rdy <= 1'b0;
			read_count  <= '0;
		end else begin
			rdy_dly     <= rdata_rdy_t;
			rdy_seen    <= rdy_dly;
			host_rd_rdy <= (rdy_dly != rdy_seen);          // Pulse 2 clocks after the toggle.
			if (host_rd_rdy) read_count <= read_count + 1'b1; // Completed reads.
		end
	end

	// Byte select, in step with the pulse.
	always_ff @(posedge DDR3_CLK_25) begin
		rdata_q      <= rdata;
		host_rd_data <= rdata_q.data[{lane, 3'b000} +: 8];
	end

endmodule

// ==== design/seq_word_store.sv ====
/*
 * Word store, standing in for the DDR3 sequencer.
 * 256 x 128 bit words behind the cmd_ena_t / busy_t toggle port.
 * Zero fills itself after reset, then does masked writes and
 * pipelined reads that toggle rdata_rdy_t per returned word.
 */
`timescale 1ns/1ps

module seq_word_store (
	input  logic                      DDR3_CLK_25,
	input  logic                      RESET,
	input  logic                      cmd_ena_t,
	input  ddr3_dbg_pkg::seq_cmd_t    seq_cmd,
	output logic                      busy_t,
	output ddr3_dbg_pkg::seq_rdata_t  rdata,
	output logic                      rdata_rdy_t,
	output logic                      store_ready
);
	import ddr3_dbg_pkg::*;

	logic [WORD_BITS-1:0]      mem [1 << WORD_ADDR_BITS]; // Word array.
	store_state_t              state;
	logic [WORD_ADDR_BITS-1:0] clr_addr; // Zero fill pointer.
	logic                      accept;   // Command taken this clock.
	logic                      wr_pend;  // Masked write due next clock.
	logic [WORD_ADDR_BITS-1:0] wr_addr;
	logic [WORD_BITS-1:0]      wr_data;
	logic [WORD_BYTES-1:0]     wr_mask;
	logic [READ_LATENCY-1:0]   rd_vld;                // Read valid per stage.
	seq_rdata_t                rd_pipe [READ_LATENCY]; // Read data per stage.

	assign accept      = (cmd_ena_t != busy_t) && (state == READY);
	assign store_ready = (state == READY);

	// ******************************
	// Control and handshake.
	// ******************************
	always_ff @(posedge DDR3_CLK_25) begin
		if (RESET) begin
			state       <= CLEARING;
			clr_addr    <= '0;
			busy_t      <= 1'b0;
			wr_pend     <= 1'b0;
			rd_vld      <= '0;
			rdata_rdy_t <= 1'b0;
		end else begin
			if (state == CLEARING) begin
				clr_addr <= clr_addr + 1'b1;
				if (clr_addr == '1) state <= READY; // Last word zeroed.
			end

			if (accept) busy_t <= cmd_ena_t; // Acknowledge by matching the toggle.

			wr_pend <= accept && seq_cmd.write;
			rd_vld  <= {rd_vld[READ_LATENCY-2:0], accept && !seq_cmd.write};

			if (rd_vld[READ_LATENCY-1]) rdata_rdy_t <= !rdata_rdy_t; // One toggle per read.
		end
	end

	// ******************************
	// Word array.
	// ******************************
	always_ff @(posedge DDR3_CLK_25) begin
		if (state == CLEARING) begin
			mem[clr_addr] <= '0;
		end else if (wr_pend) begin
			for (int i = 0; i < WORD_BYTES; i++) begin
				if (wr_mask[i]) mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8]; // Masked lanes only.
			end
		end
	end

	// Write capture and read pipeline.
	always_ff @(posedge DDR3_CLK_25) begin
		if (accept) begin
			wr_addr         <= seq_cmd.addr;
			wr_data         <= seq_cmd.wdata;
			wr_mask         <= seq_cmd.wmask;
			rd_pipe[0].data <= mem[seq_cmd.addr];
			rd_pipe[0].vect <= seq_cmd.vect; // Vector rides with the data.
		end
		for (int i = 1; i < READ_LATENCY; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
		if (rd_vld[READ_LATENCY-1]) rdata <= rd_pipe[READ_LATENCY-1]; // Held until the next read.
	end

	// A command toggled in during the clear sweep stays pending until READY.
	a_cmd_held_clearing: assert property (@(posedge DDR3_CLK_25) disable iff (RESET)
		((state == CLEARING) && (cmd_ena_t != busy_t)) |=> (cmd_ena_t != busy_t));

	// An accepted write enables exactly one lane.
	a_write_onehot: assert property (@(posedge DDR3_CLK_25) disable iff (RESET)
		(accept && seq_cmd.write) |-> $onehot(seq_cmd.wmask));

endmodule

// ==== design/status_report.sv ====
/*
 * Status LEDs.
 * Packs store_ready and the low read count bits into one byte
 * and drives it onto the active low LEDs.
 */
`timescale 1ns/1ps

module status_report (
	input  logic        DDR3_CLK_25,
	input  logic        RESET,
	input  logic        store_ready,
	input  logic [15:0] read_count,
	output logic [7:0]  led
);

	logic [7:0] status; // Bit 0 ready, bits 7:1 read count.

	always_ff @(posedge DDR3_CLK_25) begin
		if (RESET) begin
			status <= 8'h00; // All LEDs dark.
		end else begin
			status <= {read_count[6:0], store_ready};
		end
	end

	assign led = ~status; // LEDs light on a low.

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DDR3 debug host testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_ddr3_dbg -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_ddr3_dbg > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q -x 'All tests passed!' "$LOG"; then
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi

// ==== sim.f ====
+incdir+test
design/ddr3_dbg_pkg.sv
design/host_cmd_bridge.sv
design/seq_word_store.sv
design/read_return.sv
design/status_report.sv
design/ddr3_dbg_top.sv
test/tb_ddr3_dbg.sv

// ==== test/ddr3_dbg_model.svh ====
/*
 * Byte array reference model for the DDR3 debug host.
 * 4096 bytes, one per host address, zero after reset like the word store.
 */
`ifndef DDR3_DBG_MODEL_SVH
`define DDR3_DBG_MODEL_SVH

logic [7:0] ref_mem [4096]; // One entry per host byte address.

// Zero fill, matching the store's clear after reset.
task automatic zero_ref_mem();
	for (int i = 0; i < 4096; i++) begin
		ref_mem[i] = 8'h00;
	end
endtask

// A host write lands on its own byte only.
task automatic put_ref_byte(input logic [11:0] addr, input logic [7:0] data);
	ref_mem[addr] = data;
endtask

// Expected byte for a host read.
function automatic logic [7:0] get_ref_byte(input logic [11:0] addr);
	return ref_mem[addr];
endfunction

`endif

// ==== test/tb_ddr3_dbg.sv ====
/*
 * DDR3 debug host testbench.
 * Seeded random byte reads and writes through the host port of
 * ddr3_dbg_top, checked against a byte array model, with read
 * pulse counting and LED status checks.
 */
`timescale 1ns/1ps

module tb_ddr3_dbg;
	import ddr3_dbg_pkg::*;

	logic       DDR3_CLK_25;
	logic       RESET;
	host_req_t  host_req;
	logic       host_busy;
	logic       host_rd_rdy;
	logic [7:0] host_rd_data;
	logic       store_ready;
	logic [7:0] led;

	integer seed;         // $random state.
	int     errors;       // Data and count errors.
	int     led_errs;     // LED errors, reported by test 5.
	int     checks;
	int     tests_run;
	int     tests_failed;
	int     err_start;    // Error count when the current test began.
	int     reads_issued;
	int     pulse_count;  // host_rd_rdy pulses seen by the bench.

	`include "ddr3_dbg_model.svh"

	ddr3_dbg_top dut (
		.DDR3_CLK_25  (DDR3_CLK_25),
		.RESET        (RESET),
		.host_req     (host_req),
		.host_busy    (host_busy),
		.host_rd_rdy  (host_rd_rdy),
		.host_rd_data (host_rd_data),
		.store_ready  (store_ready),
		.led          (led)
	);

	// 4 ns clock.
	initial begin
		DDR3_CLK_25 = 1'b0;
		forever #2 DDR3_CLK_25 = ~DDR3_CLK_25;
	end

	// Pulses are counted on the falling edge, where they are stable.
	always @(negedge DDR3_CLK_25) begin
		if (RESET) pulse_count <= 0;
		else if (host_rd_rdy) pulse_count <= pulse_count + 1;
	end

	// ******************************
	// Helper tasks.
	// ******************************
	task automatic abort_run(input string why);
		$display("Timeout: %s", why);
		$display("Test failures found");
		$finish;
	endtask

	task automatic wait_host_idle();
		int cycles;
		cycles = 0;
		while (host_busy) begin
			@(negedge DDR3_CLK_25);
			cycles++;
			if (cycles > 50) abort_run("host_busy stayed high for 50 clocks");
		end
	endtask

	// Bridge holds the host off from the capture edge on.
	task automatic check_busy_raised();
		checks++;
		if (host_busy !== 1'b1) begin
			$display("Mismatch host_busy after request: got 0x%01h, expected 0x1", host_busy);
			errors++;
		end
	endtask

	task automatic write_byte(input logic [11:0] addr, input logic [7:0] data);
		wait_host_idle();
		host_req.rd    = 1'b0;
		host_req.wr    = 1'b1;
		host_req.addr  = addr;
		host_req.wdata = data;
		@(negedge DDR3_CLK_25);
		host_req = '0; // Strobe lasts one clock.
		check_busy_raised();
		put_ref_byte(addr, data);
	endtask

	task automatic read_byte(input logic [11:0] addr, output logic [7:0] data);
		int         cycles;
		logic [7:0] exp_led;
		wait_host_idle();
		host_req.rd    = 1'b1;
		host_req.wr    = 1'b0;
		host_req.addr  = addr;
		host_req.wdata = 8'h00;
		@(negedge DDR3_CLK_25);
		host_req = '0;
		check_busy_raised();
		reads_issued++;
		cycles = 0;
		while (!host_rd_rdy) begin
			@(negedge DDR3_CLK_25);
			cycles++;
			if (cycles > 50) abort_run("no host_rd_rdy pulse within 50 clocks of a read");
		end
		data = host_rd_data; // Valid with the pulse.
		// Count, then status register, settle two clocks after the pulse.
		@(negedge DDR3_CLK_25);
		@(negedge DDR3_CLK_25);
		exp_led = ~{pulse_count[6:0], 1'b1}; // Ready lit, count in bits 7:1.
		checks++;
		if (led !== exp_led) begin
			$display("Mismatch led after read %0d: got 0x%02h, expected 0x%02h",
				reads_issued, led, exp_led);
			led_errs++;
		end
	endtask

	task automatic compare_byte(input logic [11:0] addr, input logic [7:0] got,
		input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch host_rd_data at 0x%03h: got 0x%02h, expected 0x%02h",
				addr, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input int num, input string name);
		int fails;
		fails = errors - err_start;
		tests_run++;
		if (fails != 0) tests_failed++;
		$display("Test %0d %s: %s, %0d errors", num, name, (fails == 0) ? "PASS" : "FAIL", fails);
		err_start = errors;
	endtask

	// ******************************
	// Test sequence.
	// ******************************
	initial begin
		logic [31:0] r;
		logic [11:0] addr;
		logic [7:0]  data;
		logic [7:0]  got;
		logic [7:0]  base;
		logic [7:0]  waddr;
		int          cycles;
		seed         = 32'h69b5_e890;
		errors       = 0;
		led_errs     = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		err_start    = 0;
		reads_issued = 0;
		host_req     = '0;
		RESET        = 1'b1;
		zero_ref_mem();
		repeat (5) @(negedge DDR3_CLK_25);
		RESET = 1'b0;

		// 1. LEDs dark and store clearing, then ready.
		@(negedge DDR3_CLK_25);
		checks += 3;
		if (led !== 8'hff) begin
			$display("Mismatch led after reset: got 0x%02h, expected 0xff", led);
			errors++;
		end
		if (store_ready !== 1'b0) begin
			$display("Mismatch store_ready after reset: got 0x%01h, expected 0x0", store_ready);
			errors++;
		end
		if (host_busy !== 1'b0) begin
			$display("Mismatch host_busy after reset: got 0x%01h, expected 0x0", host_busy);
			errors++;
		end
		cycles = 0;
		while (!store_ready) begin
			@(negedge DDR3_CLK_25);
			cycles++;
			if (cycles > 300) abort_run("store_ready did not rise within 300 clocks of reset");
		end
		repeat (2) @(negedge DDR3_CLK_25); // Status register catches up.
		checks++;
		if (led !== 8'hfe) begin
			$display("Mismatch led after store_ready: got 0x%02h, expected 0xfe", led);
			errors++;
		end
		end_test(1, "reset and clear");

		// 2. Cleared memory reads back zero.
		repeat (8) begin
			r    = $random(seed);
			addr = r[11:0];
			read_byte(addr, got);
			compare_byte(addr, got, 8'h00);
		end
		end_test(2, "reads after clear");

		// 3. Distinct bytes across every lane of one word.
		r     = $random(seed);
		waddr = r[7:0];
		base  = r[15:8];
		for (int i = 0; i < 16; i++) begin
			write_byte({waddr, 4'(i)}, base + 8'(i * 17)); // Step 17 keeps all 16 apart.
		end
		for (int i = 0; i < 16; i++) begin
			addr = {waddr, 4'(i)};
			read_byte(addr, got);
			compare_byte(addr, got, get_ref_byte(addr));
		end
		end_test(3, "lane mapping");

		// 4. Random mixed traffic, half of it in a 64 byte window for reuse.
		for (int n = 0; n < 200; n++) begin
			r    = $random(seed);
			addr = r[22] ? {6'h2a, r[5:0]} : r[11:0];
			data = r[19:12];
			if (r[20]) begin
				write_byte(addr, data);
				if (r[21]) begin
					read_byte(addr, got);          // Straight after the write.
					compare_byte(addr, got, data);
				end
			end else begin
				read_byte(addr, got);
				compare_byte(addr, got, get_ref_byte(addr));
			end
		end
		end_test(4, "random traffic");

		// 5. LED count over every read, and one pulse per read.
		repeat (10) begin
			r    = $random(seed);
			addr = r[11:0];
			read_byte(addr, got);
			compare_byte(addr, got, get_ref_byte(addr));
		end
		checks++;
		if (pulse_count != reads_issued) begin
			$display("Mismatch host_rd_rdy pulse count: got 0x%0h, expected 0x%0h",
				pulse_count, reads_issued);
			errors++;
		end
		errors = errors + led_errs;
		end_test(5, "LED read count");

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
